/* filelist.f */
+incdir+.
sys_bus_pkg.sv
sys_map_pkg.sv
sys_bus.sv
sys_ram.sv
sys_ctrl.sv
sys_timer.sv
simple_system.sv
tb_simple_system.sv

/* Makefile */
TOP := tb_simple_system
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): filelist.f $(wildcard *.sv) $(wildcard *.svh)
	verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG) || ! grep -q "Test OK" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi

lint:
	verilator --lint-only --timing -Wall -f filelist.f --top-module simple_system

clean:
	rm -rf obj_dir $(LOG)

/* tb_simple_system.sv */
`timescale 1ns/10ps
`include "sys_macros.svh"

module tb_simple_system;
  import sys_bus_pkg::*;
  import sys_map_pkg::*;

  // Whole suite needs under 1000 cycles including reset
  localparam int max_cycles = 4000;

  typedef struct packed {
    logic  chk;
    logic  err;
    data_t rdata;
  } exp_t;

  logic        clk_i = 1'b0;
  logic        reset_i;
  bus_req_t    host_req;
  bus_req_t    acc_req;
  logic        host_gnt;
  bus_rsp_t    host_rsp;
  logic        char_valid;
  logic [7:0]  char_byte;
  logic        halt;
  logic        timer_irq;

  int          cycle = 0;
  int          errors = 0;
  int          test_base = 0;
  int          tests_run = 0;
  int          tests_passed = 0;
  exp_t        exp_q [$];
  data_t       ram_m [addr_t];
  logic [63:0] cmp_m = '1;
  logic        halt_m;
  data_t       last_rdata;

  simple_system dut0 (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .host_req_i   (host_req),
    .host_gnt_o   (host_gnt),
    .host_rsp_o   (host_rsp),
    .char_valid_o (char_valid),
    .char_o       (char_byte),
    .halt_o       (halt),
    .timer_irq_o  (timer_irq)
  );

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle <= cycle + 1;
    if (cycle >= max_cycles) begin
      $display("timeout: run did not finish within %0d cycles", max_cycles);
      $display("Test FAILED");
      $finish;
    end
  end

  // Address map as windows of 4 KB and 1 KB
  function automatic dev_e dev_of(addr_t addr);
    if (addr >= `SYS_RAM_BASE && addr < `SYS_RAM_BASE + 32'h1000) begin
      return DevRam;
    end
    if (addr >= `SYS_CTRL_BASE && addr < `SYS_CTRL_BASE + 32'h400) begin
      return DevCtrl;
    end
    if (addr >= `SYS_TIMER_BASE && addr < `SYS_TIMER_BASE + 32'h400) begin
      return DevTimer;
    end
    return DevNone;
  endfunction

  function automatic data_t merge_bytes(data_t old, data_t wdata, be_t be);
    data_t res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic addr_t ram_addr(int unsigned idx);
    return `SYS_RAM_BASE + addr_t'(idx * 4);
  endfunction

  function automatic addr_t timer_addr(reg_off_t off);
    return `SYS_TIMER_BASE + addr_t'(off);
  endfunction

  task automatic report_mismatch(input string name, input data_t got, input data_t exp);
    $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
    errors++;
  endtask

  // Drive one request, then queue its expected response once accepted
  task automatic issue(input logic we, input addr_t addr, input data_t wdata, input be_t be,
                       output int stamp);
    exp_t     e;
    reg_off_t off;
    host_req = '{req: 1'b1, we: we, be: be, addr: addr, wdata: wdata};
    @(posedge clk_i);
    #1;
    stamp = cycle;
    host_req.req = 1'b0;
    off = addr[`SYS_REG_OFF_W-1:0];
    e = '{chk: 1'b1, err: 1'b0, rdata: '0};
    case (dev_of(addr))
      DevNone: e.err = 1'b1;
      DevRam: begin
        if (we) begin
          ram_m[addr >> 2] = merge_bytes(ram_m.exists(addr >> 2) ? ram_m[addr >> 2] : '0,
                                         wdata, be);
        end else begin
          e.rdata = ram_m[addr >> 2];
        end
      end
      DevTimer: begin
        case (off)
          `SYS_MTCMP_LO: begin
            if (we) cmp_m[31:0] = wdata;
            else e.rdata = cmp_m[31:0];
          end
          `SYS_MTCMP_HI: begin
            if (we) cmp_m[63:32] = wdata;
            else e.rdata = cmp_m[63:32];
          end
          // mtime values are checked by the tests themselves
          `SYS_MTIME_LO, `SYS_MTIME_HI: e.chk = we;
          default: begin
            e.err = 1'b1;
            e.chk = 1'b0;
          end
        endcase
      end
      default: ;
    endcase
    exp_q.push_back(e);
  endtask

  // Wait past the falling edge so the response checker has run
  task automatic drain();
    while (exp_q.size() != 0) begin
      @(negedge clk_i);
      #1;
    end
    @(posedge clk_i);
    #1;
  endtask

  task automatic access(input logic we, input addr_t addr, input data_t wdata, input be_t be,
                        output data_t rdata, output int stamp);
    issue(we, addr, wdata, be, stamp);
    drain();
    rdata = last_rdata;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == test_base) begin
      tests_passed++;
      $display("%s: pass", name);
    end else begin
      $display("%s: %0d errors", name, errors - test_base);
    end
    test_base = errors;
  endtask

  // Response, character and halt checks on every falling edge
  always @(negedge clk_i) begin
    exp_t e;
    logic char_exp;
    if (!reset_i) begin
      assert (host_gnt == host_req.req)
        else report_mismatch("host_gnt_o", data_t'(host_gnt), data_t'(host_req.req));
      assert (host_rsp.rvalid == acc_req.req)
        else report_mismatch("host_rsp_o.rvalid", data_t'(host_rsp.rvalid), data_t'(acc_req.req));
      if (host_rsp.rvalid && exp_q.size() == 0) begin
        $display("response arrived with no request outstanding");
        errors++;
      end else if (host_rsp.rvalid) begin
        e = exp_q.pop_front();
        assert (host_rsp.err == e.err)
          else report_mismatch("host_rsp_o.err", data_t'(host_rsp.err), data_t'(e.err));
        if (e.chk) begin
          assert (host_rsp.rdata == e.rdata)
            else report_mismatch("host_rsp_o.rdata", host_rsp.rdata, e.rdata);
        end
        last_rdata = host_rsp.rdata;
      end
      char_exp = acc_req.req && acc_req.we && dev_of(acc_req.addr) == DevCtrl &&
                 acc_req.addr[`SYS_REG_OFF_W-1:0] == `SYS_CTRL_CHAR;
      assert (char_valid == char_exp)
        else report_mismatch("char_valid_o", data_t'(char_valid), data_t'(char_exp));
      if (char_exp) begin
        assert (char_byte == acc_req.wdata[7:0])
          else report_mismatch("char_o", data_t'(char_byte), data_t'(acc_req.wdata[7:0]));
      end
      if (acc_req.req && acc_req.we && dev_of(acc_req.addr) == DevCtrl &&
          acc_req.addr[`SYS_REG_OFF_W-1:0] == `SYS_CTRL_HALT && acc_req.wdata[0]) begin
        halt_m = 1'b1;
      end
      assert (halt == halt_m) else report_mismatch("halt_o", data_t'(halt), data_t'(halt_m));
    end else begin
      halt_m = 1'b0;
    end
    acc_req = reset_i ? '0 : host_req;
  end

  initial begin
    addr_t words [8];
    addr_t bad [4] = '{32'h0000_0000, 32'h0010_1000, 32'h0002_0400, 32'hFFFF_FFFC};
    addr_t a;
    data_t rd;
    data_t r1;
    data_t r2;
    data_t target;
    logic  irq_exp;
    int    st;
    int    c1;
    int    c2;
    void'($urandom(32'hb71e));
    reset_i  = 1'b1;
    host_req = '0;
    repeat (10) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    // Full RAM words first so partial writes merge into known data
    foreach (words[i]) begin
      words[i] = ram_addr($urandom_range(1023, 0));
      access(1'b1, words[i], $urandom(), 4'hF, rd, st);
    end
    foreach (words[i]) access(1'b1, words[i], $urandom(), be_t'($urandom_range(15, 0)), rd, st);
    foreach (words[i]) access(1'b0, words[i], '0, 4'h0, rd, st);
    finish_test("ram_byte_enable");

    for (int i = 0; i < 8; i++) begin
      if (i < 4) begin
        a = bad[i];
      end else begin
        do a = $urandom(); while (dev_of(a) != DevNone);
      end
      access(1'b0, a, '0, 4'h0, rd, st);
      access(1'b1, a, $urandom(), 4'hF, rd, st);
    end
    finish_test("unmapped_error");

    repeat (4) access(1'b1, `SYS_CTRL_BASE, $urandom(), 4'hF, rd, st);
    access(1'b1, `SYS_CTRL_BASE + 32'h4, $urandom(), 4'hF, rd, st);
    access(1'b0, `SYS_CTRL_BASE, '0, 4'h0, rd, st);
    finish_test("char_output");

    access(1'b1, `SYS_CTRL_BASE + 32'h8, 32'h0, 4'hF, rd, st);
    access(1'b1, `SYS_CTRL_BASE + 32'h8, 32'h1, 4'hF, rd, st);
    foreach (words[i]) access(1'b0, words[i], '0, 4'h0, rd, st);
    access(1'b1, `SYS_CTRL_BASE, 32'h41, 4'hF, rd, st);
    assert (halt == 1'b1) else report_mismatch("halt_o", data_t'(halt), 32'h1);
    finish_test("halt_flag");

    access(1'b0, timer_addr(`SYS_MTIME_LO), '0, 4'h0, r1, c1);
    repeat ($urandom_range(20, 3)) @(posedge clk_i);
    #1;
    access(1'b0, timer_addr(`SYS_MTIME_LO), '0, 4'h0, r2, c2);
    assert (r2 - r1 == data_t'(c2 - c1)) else report_mismatch("mtime delta", r2 - r1, c2 - c1);
    // Compare point just ahead of the current time
    access(1'b1, timer_addr(`SYS_MTCMP_HI), '0, 4'hF, rd, st);
    access(1'b0, timer_addr(`SYS_MTIME_LO), '0, 4'h0, r1, c1);
    target = r1 + 32'd30;
    access(1'b1, timer_addr(`SYS_MTCMP_LO), target, 4'hF, rd, st);
    repeat (50) begin
      @(negedge clk_i);
      irq_exp = (r1 + data_t'(cycle - c1)) >= target;
      assert (timer_irq == irq_exp)
        else report_mismatch("timer_irq_o", data_t'(timer_irq), data_t'(irq_exp));
    end
    @(posedge clk_i);
    #1;
    access(1'b1, timer_addr(`SYS_MTCMP_HI), 32'h1, 4'hF, rd, st);
    @(negedge clk_i);
    assert (timer_irq == 1'b0) else report_mismatch("timer_irq_o", data_t'(timer_irq), 32'h0);
    @(posedge clk_i);
    #1;
    access(1'b0, timer_addr(10'h010), '0, 4'h0, rd, st);
    finish_test("timer");

    for (int n = 0; n < 3; n++) begin
      a = ram_addr($urandom_range(1023, 0));
      issue(1'b1, a, $urandom(), 4'hF, st);
      issue(1'b0, timer_addr(`SYS_MTCMP_LO), '0, 4'h0, st);
      issue(1'b0, a, '0, 4'h0, st);
      issue(1'b1, timer_addr(`SYS_MTCMP_HI), $urandom_range(255, 1), 4'hF, st);
      issue(1'b1, a, $urandom(), be_t'($urandom_range(15, 0)), st);
      issue(1'b0, timer_addr(`SYS_MTCMP_HI), '0, 4'h0, st);
      issue(1'b0, a, '0, 4'h0, st);
      issue(1'b0, timer_addr(10'h010), '0, 4'h0, st);
    end
    drain();
    finish_test("back_to_back");

    $display("%0d tests run, %0d passed, %0d failed", tests_run, tests_passed,
             tests_run - tests_passed);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* simple_system.sv */
`timescale 1ns/10ps
`include "sys_macros.svh"

module simple_system (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  sys_bus_pkg::bus_req_t host_req_i,
  output logic                  host_gnt_o,
  output sys_bus_pkg::bus_rsp_t host_rsp_o,
  output logic                  char_valid_o,
  output logic [7:0]            char_o,
  output logic                  halt_o,
  output logic                  timer_irq_o
);
  import sys_bus_pkg::*;
  import sys_map_pkg::*;

  // One request and one response per device
  bus_req_t dev_req [`SYS_NUM_DEVS];
  bus_rsp_t dev_rsp [`SYS_NUM_DEVS];

  sys_bus u_bus (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .host_req_i (host_req_i),
    .host_gnt_o (host_gnt_o),
    .host_rsp_o (host_rsp_o),
    .dev_req_o  (dev_req),
    .dev_rsp_i  (dev_rsp)
  );

  sys_ram u_ram (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .req_i   (dev_req[DevRam]),
    .rsp_o   (dev_rsp[DevRam])
  );

  sys_ctrl u_ctrl (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_i        (dev_req[DevCtrl]),
    .rsp_o        (dev_rsp[DevCtrl]),
    .char_valid_o (char_valid_o),
    .char_o       (char_o),
    .halt_o       (halt_o)
  );

  sys_timer u_timer (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .req_i   (dev_req[DevTimer]),
    .rsp_o   (dev_rsp[DevTimer]),
    .irq_o   (timer_irq_o)
  );

endmodule

/* sys_timer.sv */
`timescale 1ns/10ps
`include "sys_macros.svh"

module sys_timer (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  sys_bus_pkg::bus_req_t req_i,
  output sys_bus_pkg::bus_rsp_t rsp_o,
  output logic                  irq_o
);
  import sys_bus_pkg::*;
  import sys_map_pkg::*;

  logic [`SYS_TIMER_W-1:0] mtime_q;
  logic [`SYS_TIMER_W-1:0] mtimecmp_q;
  reg_off_t                off;
  logic                    wr;
  logic                    off_ok;
  data_t                   rdata_d;
  data_t                   rdata_q;
  logic                    rvalid_q;
  logic                    err_q;
  logic                    irq_q;

  assign off = req_i.addr[`SYS_REG_OFF_W-1:0];
  assign wr  = req_i.req && req_i.we;

  // Readback mux and offset check
  always_comb begin
    off_ok  = 1'b1;
    rdata_d = '0;
    case (off)
      `SYS_MTIME_LO: rdata_d = mtime_q[31:0];
      `SYS_MTIME_HI: rdata_d = mtime_q[63:32];
      `SYS_MTCMP_LO: rdata_d = mtimecmp_q[31:0];
      `SYS_MTCMP_HI: rdata_d = mtimecmp_q[63:32];
      default:       off_ok  = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
    end else begin
      mtime_q <= mtime_q + 1'b1;
      // A written half replaces the incremented value
      if (wr) begin
        case (off)
          `SYS_MTIME_LO: mtime_q[31:0]     <= req_i.wdata;
          `SYS_MTIME_HI: mtime_q[63:32]    <= req_i.wdata;
          `SYS_MTCMP_LO: mtimecmp_q[31:0]  <= req_i.wdata;
          `SYS_MTCMP_HI: mtimecmp_q[63:32] <= req_i.wdata;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
      irq_q    <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
      err_q    <= req_i.req && !off_ok;
      irq_q    <= (mtime_q >= mtimecmp_q);
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= req_i.we ? '0 : rdata_d;
    end
  end

  assign rsp_o = '{rvalid: rvalid_q, err: err_q, rdata: rdata_q};
  assign irq_o = irq_q;

endmodule

/* sys_ctrl.sv */
`timescale 1ns/10ps
`include "sys_macros.svh"

module sys_ctrl (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  sys_bus_pkg::bus_req_t req_i,
  output sys_bus_pkg::bus_rsp_t rsp_o,
  output logic                  char_valid_o,
  output logic [7:0]            char_o,
  output logic                  halt_o
);
  import sys_map_pkg::*;

  reg_off_t   off;
  logic       wr;
  logic       rvalid_q;
  logic       char_valid_q;
  logic [7:0] char_q;
  logic       halt_q;

  assign off = req_i.addr[`SYS_REG_OFF_W-1:0];
  assign wr  = req_i.req && req_i.we;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q     <= 1'b0;
      char_valid_q <= 1'b0;
      halt_q       <= 1'b0;
    end else begin
      rvalid_q     <= req_i.req;
      char_valid_q <= wr && (off == `SYS_CTRL_CHAR);
      // Halt is sticky until reset
      if (wr && (off == `SYS_CTRL_HALT) && req_i.wdata[0]) begin
        halt_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr && (off == `SYS_CTRL_CHAR)) begin
      char_q <= req_i.wdata[7:0];
    end
  end

  assign char_valid_o = char_valid_q;
  assign char_o       = char_q;
  assign halt_o       = halt_q;

  // Write-only device, reads give zero
  assign rsp_o = '{rvalid: rvalid_q, err: 1'b0, rdata: '0};

endmodule

/* sys_ram.sv */
`timescale 1ns/10ps
`include "sys_macros.svh"

module sys_ram (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  sys_bus_pkg::bus_req_t req_i,
  output sys_bus_pkg::bus_rsp_t rsp_o
);
  import sys_bus_pkg::*;

  data_t                     mem [`SYS_RAM_WORDS];
  logic [`SYS_RAM_IDX_W-1:0] word_idx;
  logic                      rvalid_q;
  data_t                     rdata_q;

  // Word address within the window
  assign word_idx = req_i.addr[`SYS_RAM_IDX_W+1:2];

  always_ff @(posedge clk_i) begin
    if (req_i.req && req_i.we) begin
      for (int b = 0; b < `SYS_BE_W; b++) begin
        if (req_i.be[b]) begin
          mem[word_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // Writes answer with zero data
  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= req_i.we ? '0 : mem[word_idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  assign rsp_o = '{rvalid: rvalid_q, err: 1'b0, rdata: rdata_q};

endmodule

/* sys_bus.sv */
`timescale 1ns/10ps
`include "sys_macros.svh"

module sys_bus (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  sys_bus_pkg::bus_req_t host_req_i,
  output logic                  host_gnt_o,
  output sys_bus_pkg::bus_rsp_t host_rsp_o,
  output sys_bus_pkg::bus_req_t dev_req_o [`SYS_NUM_DEVS],
  input  sys_bus_pkg::bus_rsp_t dev_rsp_i [`SYS_NUM_DEVS]
);
  import sys_bus_pkg::*;
  import sys_map_pkg::*;

  dev_e dev_sel;
  dev_e rsp_sel_q;
  logic err_pend_q;

  function automatic logic in_window(addr_t addr, addr_t base, addr_t mask);
    return (addr & mask) == base;
  endfunction

  // Grant is never withheld
  assign host_gnt_o = host_req_i.req;

  always_comb begin
    dev_sel = DevNone;
    if (in_window(host_req_i.addr, `SYS_RAM_BASE, `SYS_RAM_MASK)) begin
      dev_sel = DevRam;
    end else if (in_window(host_req_i.addr, `SYS_CTRL_BASE, `SYS_CTRL_MASK)) begin
      dev_sel = DevCtrl;
    end else if (in_window(host_req_i.addr, `SYS_TIMER_BASE, `SYS_TIMER_MASK)) begin
      dev_sel = DevTimer;
    end
  end

  // Same request to every device, strobe only to the selected one
  always_comb begin
    for (int i = 0; i < `SYS_NUM_DEVS; i++) begin
      dev_req_o[i]     = host_req_i;
      dev_req_o[i].req = host_req_i.req && (dev_sel == dev_e'(i));
    end
  end

  // Remember who owes the response next cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_sel_q  <= DevNone;
      err_pend_q <= 1'b0;
    end else begin
      rsp_sel_q  <= host_req_i.req ? dev_sel : DevNone;
      err_pend_q <= host_req_i.req && (dev_sel == DevNone);
    end
  end

  always_comb begin
    host_rsp_o = '0;
    case (rsp_sel_q)
      DevRam:   host_rsp_o = dev_rsp_i[DevRam];
      DevCtrl:  host_rsp_o = dev_rsp_i[DevCtrl];
      DevTimer: host_rsp_o = dev_rsp_i[DevTimer];
      default: begin
        // Unmapped address, answered here with zero data
        host_rsp_o.rvalid = err_pend_q;
        host_rsp_o.err    = err_pend_q;
      end
    endcase
  end

endmodule

/* sys_map_pkg.sv */
`include "sys_macros.svh"

package sys_map_pkg;

  // Device index, also used as the bus port index
  typedef enum logic [1:0] {
    DevRam   = 2'd0,
    DevCtrl  = 2'd1,
    DevTimer = 2'd2,
    DevNone  = 2'd3
  } dev_e;

  // Byte offset inside a 1 KB device window
  typedef logic [`SYS_REG_OFF_W-1:0] reg_off_t;

endpackage

/* sys_bus_pkg.sv */
`include "sys_macros.svh"

package sys_bus_pkg;

  // Plain bus fields
  typedef logic [`SYS_DATA_W-1:0] data_t;
  typedef logic [`SYS_ADDR_W-1:0] addr_t;
  typedef logic [`SYS_BE_W-1:0]   be_t;

  // Host or device request, 70 bits
  typedef struct packed {
    logic  req;
    logic  we;
    be_t   be;
    addr_t addr;
    data_t wdata;
  } bus_req_t;

  // Response, rdata only meaningful for reads
  typedef struct packed {
    logic  rvalid;
    logic  err;
    data_t rdata;
  } bus_rsp_t;

endpackage

/* sys_macros.svh */
`ifndef SYS_MACROS_SVH
`define SYS_MACROS_SVH

// Bus widths
`define SYS_DATA_W      32
`define SYS_ADDR_W      32
`define SYS_BE_W        (`SYS_DATA_W / 8)

// Word RAM, 4 KB
`define SYS_RAM_WORDS   1024
`define SYS_RAM_IDX_W   $clog2(`SYS_RAM_WORDS)

// Device windows, base and mask per device
`define SYS_NUM_DEVS    3
`define SYS_RAM_BASE    32'h0010_0000
`define SYS_RAM_MASK    (~32'h0000_0FFF)
`define SYS_CTRL_BASE   32'h0002_0000
`define SYS_CTRL_MASK   (~32'h0000_03FF)
`define SYS_TIMER_BASE  32'h0003_0000
`define SYS_TIMER_MASK  (~32'h0000_03FF)

// Register offsets inside a 1 KB window
`define SYS_REG_OFF_W   10
`define SYS_CTRL_CHAR   10'h000
`define SYS_CTRL_HALT   10'h008
`define SYS_TIMER_W     64
`define SYS_MTIME_LO    10'h000
`define SYS_MTIME_HI    10'h004
`define SYS_MTCMP_LO    10'h008
`define SYS_MTCMP_HI    10'h00C

`endif
